/* rtl/fault_pkg.sv */
package fault_pkg;

	localparam logic [15:0] trig_cycles = 16'd500;    // 10 us at 50 MHz
	localparam int width_bits = 16;                  // echo widths and threshold
	localparam int msg_len = 10;                     // chars in the message
	localparam int msg_idx_bits = $clog2(msg_len);

	localparam logic [width_bits-1:0] threshold_default = 16'd18000;
	localparam logic [width_bits-1:0] char_cycles_default = 16'd500;

	localparam int addr_bits = 4;                    // AXI4-Lite byte address
	localparam int data_bits = 32;
	localparam logic [addr_bits-1:0] reg_threshold_addr = 4'h0;
	localparam logic [addr_bits-1:0] reg_char_cycles_addr = 4'h4;
	localparam logic [addr_bits-1:0] reg_fault_count_addr = 4'h8;   // write clears
	localparam logic [addr_bits-1:0] reg_last_width_addr = 4'hC;    // read only
	localparam logic [1:0] resp_okay = 2'b00;

	typedef enum logic {trigger, listen} ranger_state_t;
	typedef enum logic {idle, send} msg_state_t;

	typedef struct packed {
		logic valid;                     // one cycle per measurement
		logic [width_bits-1:0] width;    // clocks with echo high
	} echo_sample_t;

	typedef struct packed {
		logic red;
		logic green;
		logic blue;
	} rgb_t;

	localparam rgb_t led_off = 3'b000;
	localparam rgb_t led_green = 3'b010;
	localparam rgb_t led_blue = 3'b001;

	typedef struct packed {
		logic [width_bits-1:0] threshold;
		logic [width_bits-1:0] char_cycles;   // clocks per message byte
	} fault_cfg_t;

	typedef struct packed {
		logic [width_bits-1:0] fault_count;
		logic [width_bits-1:0] last_width;
	} fault_status_t;

endpackage

/* rtl/echo_ranger.sv */
`timescale 1ns/1ps

module echo_ranger
	import fault_pkg::*;
(
	input  logic         clk_50M,
	input  logic         reset,
	input  logic         echo,      // from ranger
	output logic         trig,      // to ranger
	output echo_sample_t sample
);

	ranger_state_t         state;
	logic [15:0]           trig_cnt;   // clocks of trigger so far
	logic [width_bits-1:0] echo_cnt;   // clocks with echo high

	always_ff @(posedge clk_50M) begin
		if (reset) begin
			state <= trigger;
			trig <= 1'b1;              // first pulse starts right away
			trig_cnt <= '0;
			echo_cnt <= '0;
			sample <= '0;
		end else begin
			sample.valid <= 1'b0;      // strobe
			case (state)
				trigger: begin
					if (trig_cnt == trig_cycles - 16'd1) begin
						state <= listen;
						trig <= 1'b0;
						trig_cnt <= '0;
					end else begin
						trig_cnt <= trig_cnt + 16'd1;
					end
				end
				listen: begin
					if (echo) begin
						if (echo_cnt != '1)   // hold at max, no timeout
							echo_cnt <= echo_cnt + width_bits'(1);
					end else if (echo_cnt != '0) begin   // falling edge of echo
						sample.valid <= 1'b1;
						sample.width <= echo_cnt;
						echo_cnt <= '0;
						state <= trigger;      // next pulse same cycle as sample
						trig <= 1'b1;
					end
				end
				default: state <= trigger;
			endcase
		end
	end

	a_no_trig_listen: assert property (@(posedge clk_50M) disable iff (reset)
		state == listen |-> !trig)
		else $error("trig high while listening");

endmodule

/* rtl/fault_detector.sv */
`timescale 1ns/1ps

module fault_detector
	import fault_pkg::*;
(
	input  logic          clk_50M,
	input  logic          reset,
	input  echo_sample_t  sample,
	input  fault_cfg_t    cfg,
	input  logic          clear_count,   // from register write
	output rgb_t [2:0]    leds,
	output logic          fault_start,   // kicks msg_sender
	output fault_status_t status
);

	logic [width_bits-1:0] prev_width;   // width of the sample before
	logic                  flag;         // set while inside a faulty box
	logic                  box_edge;

	// short previous echo means an edge of a box
	assign box_edge = sample.valid && prev_width != '0 && prev_width < cfg.threshold;

	always_ff @(posedge clk_50M) begin
		if (reset) begin
			prev_width <= '0;
			flag <= 1'b0;
			leds <= {3{led_off}};
			fault_start <= 1'b0;
			status <= '0;
		end else begin
			fault_start <= 1'b0;
			if (sample.valid) begin
				prev_width <= sample.width;
				status.last_width <= sample.width;
			end
			if (box_edge) begin
				flag <= !flag;
				if (!flag) begin           // start of box
					fault_start <= 1'b1;
					leds <= {3{led_blue}};
				end else begin             // end of box
					leds <= {3{led_green}};
				end
			end
			if (clear_count)
				status.fault_count <= '0;      // clear wins over a new fault
			else if (box_edge && !flag && status.fault_count != '1)
				status.fault_count <= status.fault_count + width_bits'(1);   // saturates
		end
	end

	a_start_pulse: assert property (@(posedge clk_50M) disable iff (reset)
		fault_start |=> !fault_start)
		else $error("fault_start longer than one cycle");

endmodule

/* rtl/msg_sender.sv */
`timescale 1ns/1ps

module msg_sender
	import fault_pkg::*;
(
	input  logic       clk_50M,
	input  logic       reset,
	input  logic       fault_start,
	input  fault_cfg_t cfg,
	output logic [7:0] msg,         // toward serial bridge
	output logic       msg_valid
);

	msg_state_t            state;
	logic [msg_idx_bits-1:0] index;   // current char
	logic [width_bits-1:0] slot_cnt;  // clocks spent on this char
	logic                  slot_done;

	function automatic logic [7:0] rom_byte(input logic [msg_idx_bits-1:0] idx);
		case (idx)
			4'd0: rom_byte = 8'h46;   // F
			4'd1: rom_byte = 8'h49;   // I
			4'd2: rom_byte = 8'h4D;   // M
			4'd3: rom_byte = 8'h2D;   // -
			4'd4: rom_byte = 8'h43;   // C
			4'd5: rom_byte = 8'h53;   // S
			4'd6: rom_byte = 8'h55;   // U
			4'd7: rom_byte = 8'h31;   // 1
			4'd8: rom_byte = 8'h2D;   // -
			default: rom_byte = 8'h23;   // #
		endcase
	endfunction

	// extra bit so a zero slot length acts as one clock
	assign slot_done = ({1'b0, slot_cnt} + 1'b1) >= {1'b0, cfg.char_cycles};

	always_ff @(posedge clk_50M) begin
		if (reset) begin
			state <= idle;
			index <= '0;
			slot_cnt <= '0;
			msg <= 8'h00;
			msg_valid <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (fault_start) begin   // only way out of idle
						state <= send;
						index <= '0;
						slot_cnt <= '0;
						msg <= rom_byte('0);
						msg_valid <= 1'b1;
					end
				end
				send: begin                  // fault_start ignored here
					if (slot_done) begin
						slot_cnt <= '0;
						if (index == msg_idx_bits'(msg_len - 1)) begin
							state <= idle;
							msg_valid <= 1'b0;
							msg <= 8'h00;
						end else begin
							index <= index + msg_idx_bits'(1);
							msg <= rom_byte(index + msg_idx_bits'(1));
						end
					end else begin
						slot_cnt <= slot_cnt + width_bits'(1);
					end
				end
				default: state <= idle;
			endcase
		end
	end

	a_index_range: assert property (@(posedge clk_50M) disable iff (reset)
		state == send |-> index < msg_idx_bits'(msg_len))
		else $error("message index out of range");

endmodule

/* rtl/fault_regs.sv */
`timescale 1ns/1ps

module fault_regs
	import fault_pkg::*;
(
	input  logic                 clk_50M,
	input  logic                 reset,
	input  logic [addr_bits-1:0] awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [data_bits-1:0] wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output logic [1:0]           bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  logic [addr_bits-1:0] araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output logic [data_bits-1:0] rdata,
	output logic [1:0]           rresp,
	output logic                 rvalid,
	input  logic                 rready,
	input  fault_status_t        status,
	output fault_cfg_t           cfg,
	output logic                 clear_count
);

	logic                 wr_go;    // write handshake on this edge
	logic                 rd_go;    // read address handshake
	logic [data_bits-1:0] rd_mux;

	assign wr_go = awready && awvalid && wready && wvalid;
	assign rd_go = arready && arvalid;
	assign bresp = resp_okay;   // never errors
	assign rresp = resp_okay;

	// 16-bit regs only see lanes 0 and 1
	function automatic logic [15:0] merge_lanes(input logic [15:0] old,
		input logic [15:0] data, input logic [1:0] strb);
		merge_lanes = old;
		if (strb[0])
			merge_lanes[7:0] = data[7:0];
		if (strb[1])
			merge_lanes[15:8] = data[15:8];
	endfunction

	always_comb begin
		case (araddr)
			reg_threshold_addr:   rd_mux = {16'd0, cfg.threshold};
			reg_char_cycles_addr: rd_mux = {16'd0, cfg.char_cycles};
			reg_fault_count_addr: rd_mux = {16'd0, status.fault_count};
			reg_last_width_addr:  rd_mux = {16'd0, status.last_width};
			default:              rd_mux = '0;   // unknown, zero data
		endcase
	end

	always_ff @(posedge clk_50M) begin   // write path
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			clear_count <= 1'b0;
			cfg.threshold <= threshold_default;
			cfg.char_cycles <= char_cycles_default;
		end else begin
			clear_count <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_go) begin
				awready <= 1'b0;
				wready <= 1'b0;
				bvalid <= 1'b1;            // held until bready
				case (awaddr)
					reg_threshold_addr:
						cfg.threshold <= merge_lanes(cfg.threshold, wdata[15:0], wstrb[1:0]);
					reg_char_cycles_addr:
						cfg.char_cycles <= merge_lanes(cfg.char_cycles, wdata[15:0], wstrb[1:0]);
					reg_fault_count_addr: clear_count <= 1'b1;
					default: ;                 // last_width and unknown ignored
				endcase
			end else if (awvalid && wvalid && !awready && !bvalid) begin
				awready <= 1'b1;            // both channels together
				wready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_50M) begin   // read control
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_go) begin
				arready <= 1'b0;
				rvalid <= 1'b1;
			end else if (arvalid && !arready && !rvalid) begin
				arready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_50M) begin
		if (rd_go)
			rdata <= rd_mux;   // captured at address handshake
	end

	a_bvalid_hold: assert property (@(posedge clk_50M) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge clk_50M) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed before rready");

endmodule

/* rtl/fault_monitor_top.sv */
`timescale 1ns/1ps

module fault_monitor_top
	import fault_pkg::*;
(
	input  logic                 clk_50M,
	input  logic                 reset,
	input  logic                 echo,
	output logic                 trig,
	output rgb_t [2:0]           leds,
	output logic [7:0]           msg,
	output logic                 msg_valid,
	input  logic [addr_bits-1:0] awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [data_bits-1:0] wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output logic [1:0]           bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  logic [addr_bits-1:0] araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output logic [data_bits-1:0] rdata,
	output logic [1:0]           rresp,
	output logic                 rvalid,
	input  logic                 rready
);

	echo_sample_t  sample;        // ranger to detector
	logic          fault_start;   // detector to sender
	logic          clear_count;   // regs to detector
	fault_cfg_t    cfg;
	fault_status_t status;

	echo_ranger ranger0 (.clk_50M, .reset, .echo, .trig, .sample);

	fault_detector detector0 (.clk_50M, .reset, .sample, .cfg, .clear_count,
		.leds, .fault_start, .status);

	msg_sender sender0 (.clk_50M, .reset, .fault_start, .cfg, .msg, .msg_valid);

	fault_regs regs0 (.clk_50M, .reset, .awaddr, .awvalid, .awready, .wdata, .wstrb,
		.wvalid, .wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready, .status, .cfg, .clear_count);

endmodule

/* bench/fault_checker.sv */
`timescale 1ns/1ps

module fault_checker
	import fault_pkg::*;
(
	input  logic                 clk_50M,
	input  logic                 reset,
	input  logic                 echo,
	input  logic                 trig,
	input  rgb_t [2:0]           leds,
	input  logic [7:0]           msg,
	input  logic                 msg_valid,
	input  logic [addr_bits-1:0] awaddr,
	input  logic                 awvalid,
	input  logic                 awready,
	input  logic [31:0]          wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	input  logic                 wready,
	input  logic [1:0]           bresp,
	input  logic                 bvalid,
	input  logic                 bready,
	input  logic [addr_bits-1:0] araddr,
	input  logic                 arvalid,
	input  logic                 arready,
	input  logic [31:0]          rdata,
	input  logic [1:0]           rresp,
	input  logic                 rvalid,
	input  logic                 rready,
	output int                   errors,
	output int                   checks
);

	localparam logic [8*msg_len-1:0] msg_text = "FIM-CSU1-#";   // first char in top byte
	localparam rgb_t off_led = '{red: 1'b0, green: 1'b0, blue: 1'b0};
	localparam rgb_t green_led = '{red: 1'b0, green: 1'b1, blue: 1'b0};
	localparam rgb_t blue_led = '{red: 1'b0, green: 1'b0, blue: 1'b1};

	logic [15:0] thr, cc;          // register model
	logic [15:0] count, last_w;
	logic [15:0] prev_w;           // detector model
	logic        flag;
	rgb_t [2:0]  exp_leds;
	logic [15:0] ecnt, pend_w;     // echo width seen on the pin
	logic        pend;             // sample issued on the last edge
	logic        clear_due;        // fault_count write one edge ago
	logic [31:0] exp_rd;           // captured at address handshake
	logic        busy, prev_valid;   // message stream tracking
	int          idx, run, start_in;
	int          trig_run;         // clocks of trig high so far

	// only lanes 0 and 1 reach a 16-bit register
	function automatic logic [15:0] apply_strobes(input logic [15:0] cur,
		input logic [31:0] data, input logic [3:0] strb);
		logic [15:0] mask;
		mask = {{8{strb[1]}}, {8{strb[0]}}};
		apply_strobes = (cur & ~mask) | (data[15:0] & mask);
	endfunction

	function automatic logic [31:0] read_value(input logic [addr_bits-1:0] addr);
		case (addr)
			reg_threshold_addr:   read_value = {16'd0, thr};
			reg_char_cycles_addr: read_value = {16'd0, cc};
			reg_fault_count_addr: read_value = {16'd0, count};
			reg_last_width_addr:  read_value = {16'd0, last_w};
			default:              read_value = 32'd0;   // unknown offset
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("%s at %0t", what, $time);
	endtask

	// start two edges after the fault, each byte held for cc clocks
	task automatic track_message();
		if (msg_valid && !prev_valid) begin
			if (start_in != 1)
				report_problem("message started without a new fault");
			idx = 0;
			run = 0;
		end else if (start_in == 1) begin
			report_problem("message did not start after a fault");
		end
		if (msg_valid) begin
			if (idx >= msg_len) begin
				report_problem("message longer than ten bytes");
			end else begin
				check_value("msg", {24'd0, msg_text[8*(msg_len-1-idx) +: 8]}, {24'd0, msg});
				run++;
				if (run >= int'(cc)) begin   // slot over
					run = 0;
					idx++;
				end
			end
		end else if (prev_valid) begin
			if (idx != msg_len || run != 0)
				report_problem("message ended early");
			busy = 1'b0;
		end
		if (start_in != 0)
			start_in--;
		prev_valid = msg_valid;
	endtask

	always @(posedge clk_50M) begin
		if (reset) begin
			thr = 16'd18000;
			cc = 16'd500;
			count = '0;
			last_w = '0;
			prev_w = '0;
			flag = 1'b0;
			exp_leds = {3{off_led}};
			ecnt = '0;
			pend_w = '0;
			pend = 1'b0;
			clear_due = 1'b0;
			exp_rd = '0;
			busy = 1'b0;
			prev_valid = 1'b0;
			idx = 0;
			run = 0;
			start_in = 0;
			trig_run = 0;
			errors = 0;
			checks = 0;
		end else begin
			check_value("leds", {23'd0, exp_leds}, {23'd0, leds});   // state after last edge
			if (bvalid && bready)
				check_value("bresp", 32'd0, {30'd0, bresp});   // always OKAY
			if (rvalid && rready) begin
				check_value("rdata", exp_rd, rdata);
				check_value("rresp", 32'd0, {30'd0, rresp});
			end
			if (arvalid && arready)
				exp_rd = read_value(araddr);
			if (trig) begin
				trig_run++;
			end else if (trig_run != 0) begin   // pulse just ended
				check_value("trig cycles", {16'd0, trig_cycles}, trig_run);
				trig_run = 0;
			end
			track_message();
			if (pend) begin                      // detector acts one edge after sample
				check_value("trig", 32'd1, {31'd0, trig});   // restarted with the sample
				if (prev_w != '0 && prev_w < thr) begin   // box edge
					flag = !flag;
					if (flag) begin
						exp_leds = {3{blue_led}};
						if (count != 16'hFFFF)
							count++;
						if (!busy) begin         // one message in flight
							busy = 1'b1;
							start_in = 2;
						end
					end else begin
						exp_leds = {3{green_led}};
					end
				end
				prev_w = pend_w;
				last_w = pend_w;
				pend = 1'b0;
			end
			if (clear_due) begin                 // clear beats a fault on the same edge
				count = '0;
				clear_due = 1'b0;
			end
			if (awvalid && awready && wvalid && wready) begin
				case (awaddr)
					reg_threshold_addr:   thr = apply_strobes(thr, wdata, wstrb);
					reg_char_cycles_addr: cc = apply_strobes(cc, wdata, wstrb);
					reg_fault_count_addr: clear_due = 1'b1;
					default: ;                   // last_width is read only
				endcase
			end
			if (echo) begin
				ecnt++;
			end else if (ecnt != '0) begin       // falling echo gives a sample
				pend = 1'b1;
				pend_w = ecnt;
				ecnt = '0;
			end
		end
	end

endmodule

/* bench/tb_fault_monitor.sv */
`timescale 1ns/1ps

module tb_fault_monitor
	import fault_pkg::*;
();

	typedef struct packed {
		logic [15:0] width;         // zero takes an LFSR width
		logic [15:0] char_cycles;   // slot length in force for the row
		logic        clear;         // clear fault_count after the row
	} row_t;

	localparam int n_rows = 18;

	// threshold is 200 during the rows
	row_t rows [0:n_rows-1] = '{
		'{16'd1000, 16'd8, 1'b0},
		'{16'd50, 16'd8, 1'b0},
		'{16'd1000, 16'd8, 1'b0},     // flag sets here
		'{16'd50, 16'd8, 1'b0},
		'{16'd1000, 16'd8, 1'b0},     // flag clears
		'{16'd300, 16'd500, 1'b0},
		'{16'd50, 16'd500, 1'b0},
		'{16'd300, 16'd500, 1'b0},    // long message starts
		'{16'd50, 16'd500, 1'b0},
		'{16'd300, 16'd500, 1'b0},
		'{16'd50, 16'd500, 1'b0},
		'{16'd300, 16'd500, 1'b0},    // fault while still sending
		'{16'd300, 16'd500, 1'b1},
		'{16'd0, 16'd8, 1'b0},
		'{16'd0, 16'd8, 1'b0},
		'{16'd0, 16'd8, 1'b0},
		'{16'd0, 16'd8, 1'b0},
		'{16'd0, 16'd8, 1'b0}
	};

	logic                 clk_50M = 1'b0;
	logic                 reset;
	logic                 echo;
	logic                 trig;
	rgb_t [2:0]           leds;
	logic [7:0]           msg;
	logic                 msg_valid;
	logic [addr_bits-1:0] awaddr, araddr;
	logic                 awvalid, awready, wvalid, wready, bvalid, bready;
	logic                 arvalid, arready, rvalid, rready;
	logic [31:0]          wdata, rdata;
	logic [3:0]           wstrb;
	logic [1:0]           bresp, rresp;
	logic [31:0]          lfsr = 32'h27d9bfa2;
	logic [15:0]          cur_width = 16'd1000;   // used by the echo model
	int                   cur_row = -1;
	int                   done_row = -1;          // row of the last finished echo
	int                   chk_errors, chk_checks;

	always #10 clk_50M = ~clk_50M;

	fault_monitor_top dut0 (.*);

	fault_checker chk0 (.*, .errors(chk_errors), .checks(chk_checks));

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [15:0] random_width(input int nbits);
		logic [15:0] v;
		int i;
		v = '0;
		for (i = 0; i < nbits; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		random_width = v + 16'd1;    // never zero
	endfunction

	task automatic write_reg(input logic [addr_bits-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(posedge clk_50M);
		#1;
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		wvalid = 1'b1;
		do @(posedge clk_50M); while (!(awready && wready));
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		do @(posedge clk_50M); while (!bvalid);
		#1;
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [addr_bits-1:0] addr, output logic [31:0] data);
		@(posedge clk_50M);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		do @(posedge clk_50M); while (!arready);
		#1;
		arvalid = 1'b0;
		rready = 1'b1;
		do @(posedge clk_50M); while (!rvalid);
		data = rdata;
		#1;
		rready = 1'b0;
	endtask

	// echo answers each falling trig
	initial begin : echo_model
		int          row_taken;
		logic [15:0] w;
		echo = 1'b0;
		forever begin
			@(negedge trig);
			w = cur_width;
			row_taken = cur_row;
			@(posedge clk_50M);
			#1 echo = 1'b1;
			repeat (w) @(posedge clk_50M);   // w edges see echo high
			#1 echo = 1'b0;
			done_row = row_taken;
		end
	end

	initial begin : stimulus
		logic [31:0] rd;
		logic [15:0] cur_cc;
		logic [15:0] w;
		int          r;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (10) @(posedge clk_50M);
		#1 reset = 1'b0;
		read_reg(reg_threshold_addr, rd);      // defaults
		read_reg(reg_char_cycles_addr, rd);
		read_reg(reg_fault_count_addr, rd);
		write_reg(reg_threshold_addr, 32'd200, 4'hF);
		write_reg(reg_char_cycles_addr, 32'd8, 4'hF);
		read_reg(reg_threshold_addr, rd);
		read_reg(reg_char_cycles_addr, rd);
		write_reg(reg_threshold_addr, 32'h0000_1234, 4'b0010);   // upper lane only
		read_reg(reg_threshold_addr, rd);
		write_reg(reg_threshold_addr, 32'h0000_0000, 4'b0010);   // back to 200
		read_reg(reg_threshold_addr, rd);
		write_reg(reg_last_width_addr, 32'h0000_FFFF, 4'hF);     // read only, ignored
		read_reg(reg_last_width_addr, rd);
		read_reg(4'h2, rd);                    // unknown offset reads zero
		cur_cc = 16'd8;
		for (r = 0; r < n_rows; r++) begin
			if (rows[r].char_cycles != cur_cc) begin
				while (msg_valid)
					@(posedge clk_50M);          // between messages only
				cur_cc = rows[r].char_cycles;
				write_reg(reg_char_cycles_addr, {16'd0, cur_cc}, 4'hF);
			end
			w = (rows[r].width == '0) ? random_width(9) : rows[r].width;
			cur_width = w;
			cur_row = r;
			wait (done_row == r);
			repeat (3) @(posedge clk_50M);      // sample reaches status
			read_reg(reg_last_width_addr, rd);
			read_reg(reg_fault_count_addr, rd);
			if (rows[r].clear) begin
				write_reg(reg_fault_count_addr, 32'd0, 4'hF);
				read_reg(reg_fault_count_addr, rd);
			end
		end
		while (msg_valid)
			@(posedge clk_50M);
		repeat (5) @(posedge clk_50M);
		$display("summary: %0d checks, %0d errors", chk_checks, chk_errors);
		if (chk_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// worst case per row is trigger plus width plus a whole message
	initial begin : watchdog
		longint limit;
		int     r;
		limit = 4000;                             // reset and register setup
		for (r = 0; r < n_rows; r++)
			limit += 600 + ((rows[r].width == '0) ? 512 : int'(rows[r].width))
				+ msg_len * int'(rows[r].char_cycles);
		repeat (limit) @(posedge clk_50M);
		$display("watchdog expired after %0d cycles and the run did not finish", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* vlog.f */
rtl/fault_pkg.sv
rtl/echo_ranger.sv
rtl/fault_detector.sv
rtl/msg_sender.sv
rtl/fault_regs.sv
rtl/fault_monitor_top.sv
bench/fault_checker.sv
bench/tb_fault_monitor.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_fault_monitor -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_fault_monitor)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
